//--- sources.f
+incdir+include
src/pu_pkg.sv
src/pu_cfg_write_decode.sv
src/pu_policy_reg.sv
src/pu_resp_slot.sv
src/pu_cfg_read_mux.sv
src/pu_cfg_top.sv
sim/pu_cfg_tb.sv

//--- Makefile
# Verilator build and run for the MPU configuration block

VERILATOR ?= verilator
TOP       ?= pu_cfg_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/pu_cfg_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module pu_cfg_tb
  import pu_pkg::*;
();

  localparam int TIMEOUT = 64;
  // Stored policy bits with two per configured domain
  localparam data_t POL_MASK = data_t'((64'd1 << (2 * `PU_NUM_DOMAINS)) - 64'd1);

  logic  clk;
  logic  rst_n;
  logic  awvalid, awready, wvalid, wready, bvalid, bready;
  logic  arvalid, arready, rvalid, rready;
  addr_t awaddr, araddr;
  prot_t awprot, arprot;
  data_t wdata, rdata, ctrl;
  strb_t wstrb;
  resp_e bresp, rresp;
  policy_word_t [`PU_NUM_MEM_REGIONS-1:0] policy;

  // Reference register model
  data_t ctrl_m;
  data_t pol_m [`PU_NUM_MEM_REGIONS];

  // Stimulus table with one entry per transaction
  bit    ent_wr   [$];
  addr_t ent_addr [$];
  data_t ent_data [$];
  strb_t ent_strb [$];
  prot_t ent_prot [$];
  int    ent_rdy  [$];
  resp_e ent_resp [$];

  logic [15:0] lfsr_q = 16'd99;

  pu_cfg_top pu_cfg_top_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .awvalid_i (awvalid), .awaddr_i (awaddr), .awprot_i (awprot), .awready_o (awready),
    .wvalid_i (wvalid), .wdata_i (wdata), .wstrb_i (wstrb), .wready_o (wready),
    .bvalid_o (bvalid), .bresp_o (bresp), .bready_i (bready),
    .arvalid_i (arvalid), .araddr_i (araddr), .arprot_i (arprot), .arready_o (arready),
    .rvalid_o (rvalid), .rdata_o (rdata), .rresp_o (rresp), .rready_i (rready),
    .ctrl_o (ctrl), .policy_o (policy)
  );

  always #20 clk = !clk;

  // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic lfsr_bit();
    logic out;
    out    = lfsr_q[15];
    lfsr_q = {lfsr_q[14:0], ^(lfsr_q & 16'hB400)};
    return out;
  endfunction

  function automatic data_t rand_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic report_mismatch(input string name, input data_t got, input data_t exp);
    $display("** Error: %s = %h, expected %h", name, got, exp);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s within %0d cycles", what, TIMEOUT);
    $display("Errors found");
    $fatal(1);
  endtask

  // Address map as the bus sees it
  function automatic bit is_ctrl(input addr_t a);
    return (a >> 2) == (`PU_CTRL_OFFSET >> 2);
  endfunction

  function automatic int region_of(input addr_t a);
    return (int'(a) - int'(`PU_POLICY_BASE)) / 4;
  endfunction

  // Byte strobes applied first and bits of unconfigured domains dropped after
  task automatic model_write(input addr_t a, input data_t d, input strb_t s);
    data_t cur;
    cur = is_ctrl(a) ? ctrl_m : pol_m[region_of(a)];
    for (int b = 0; b < `PU_STRB_WIDTH; b++)
    begin
      if (s[b])
        cur[8*b +: 8] = d[8*b +: 8];
    end
    if (is_ctrl(a))
      ctrl_m = cur;
    else
      pol_m[region_of(a)] = cur & POL_MASK;
  endtask

  function automatic data_t model_read(input addr_t a);
    return is_ctrl(a) ? ctrl_m : pol_m[region_of(a)];
  endfunction

  task automatic check_outputs();
    assert (ctrl == ctrl_m) else report_mismatch("ctrl_o", ctrl, ctrl_m);
    for (int r = 0; r < `PU_NUM_MEM_REGIONS; r++)
    begin
      assert (data_t'(policy[r]) == pol_m[r])
        else report_mismatch($sformatf("policy_o[%0d]", r), data_t'(policy[r]), pol_m[r]);
    end
  endtask

  task automatic add_entry(input bit wr, input addr_t a, input data_t d, input strb_t s,
                           input prot_t p, input int rdy, input resp_e r);
    ent_wr.push_back(wr);
    ent_addr.push_back(a);
    ent_data.push_back(d);
    ent_strb.push_back(s);
    ent_prot.push_back(p);
    ent_rdy.push_back(rdy);
    ent_resp.push_back(r);
  endtask

  task automatic build_table();
    // Reset values
    add_entry(0, 7'h00, '0, '0, 3'b001, 0, RESP_OKAY);
    for (int r = 0; r < `PU_NUM_MEM_REGIONS; r++)
      add_entry(0, addr_t'(`PU_POLICY_BASE + 4 * r), '0, '0, 3'b001, 1, RESP_OKAY);
    // Control word with full strobe
    add_entry(1, 7'h00, rand_bits(32), 4'hF, 3'b001, 2, RESP_OKAY);
    add_entry(0, 7'h00, '0, '0, 3'b011, 0, RESP_OKAY);
    // Policy words with partial strobes and the domain mask
    add_entry(1, 7'h44, 32'hFFFF_FFFF, 4'hF, 3'b001, 0, RESP_OKAY);
    add_entry(1, 7'h44, 32'h0000_1200, 4'h2, 3'b101, 1, RESP_OKAY);
    add_entry(0, 7'h44, '0, '0, 3'b001, 0, RESP_OKAY);
    add_entry(1, 7'h48, rand_bits(32), strb_t'(rand_bits(4)), 3'b001, 3, RESP_OKAY);
    add_entry(0, 7'h48, '0, '0, 3'b001, 0, RESP_OKAY);
    add_entry(1, 7'h4C, rand_bits(32), 4'h1, 3'b111, 0, RESP_OKAY);
    add_entry(0, 7'h4C, '0, '0, 3'b001, 2, RESP_OKAY);
    // Unmapped offsets
    add_entry(1, 7'h10, rand_bits(32), 4'hF, 3'b001, 0, RESP_SLVERR);
    add_entry(0, 7'h10, '0, '0, 3'b001, 1, RESP_SLVERR);
    add_entry(1, 7'h50, rand_bits(32), 4'hF, 3'b001, 0, RESP_SLVERR);
    add_entry(0, 7'h50, '0, '0, 3'b001, 0, RESP_SLVERR);
    add_entry(0, 7'h7C, '0, '0, 3'b001, 0, RESP_SLVERR);
    // Unprivileged accesses
    add_entry(1, 7'h00, rand_bits(32), 4'hF, 3'b000, 1, RESP_SLVERR);
    add_entry(0, 7'h00, '0, '0, 3'b010, 0, RESP_SLVERR);
    add_entry(1, 7'h40, rand_bits(32), 4'hF, 3'b110, 0, RESP_SLVERR);
    add_entry(0, 7'h00, '0, '0, 3'b001, 0, RESP_OKAY);
    add_entry(0, 7'h40, '0, '0, 3'b001, 0, RESP_OKAY);
  endtask

  task automatic wait_accept(input bit is_rd);
    int n;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        report_timeout("request not accepted");
    end
    while (!(is_rd ? arready : (awready && wready)));
  endtask

  // Waits for valid and holds ready low for dly cycles before taking the response
  task automatic take_resp(input bit is_rd, input int dly, input resp_e exp_resp,
                           input data_t exp_data);
    int n;
    n = 0;
    while (!(is_rd ? rvalid : bvalid))
    begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        report_timeout("response valid never rose");
    end
    repeat (dly) @(posedge clk);
    if (is_rd)
      rready <= 1'b1;
    else
      bready <= 1'b1;
    @(posedge clk);
    if (is_rd)
    begin
      assert (rvalid) else report_mismatch("rvalid_o", data_t'(rvalid), 32'd1);
      assert (rresp == exp_resp) else report_mismatch("rresp_o", data_t'(rresp), data_t'(exp_resp));
      assert (rdata == exp_data) else report_mismatch("rdata_o", rdata, exp_data);
    end
    else
    begin
      assert (bvalid) else report_mismatch("bvalid_o", data_t'(bvalid), 32'd1);
      assert (bresp == exp_resp) else report_mismatch("bresp_o", data_t'(bresp), data_t'(exp_resp));
    end
    rready <= 1'b0;
    bready <= 1'b0;
  endtask

  task automatic apply_entry(input int i);
    data_t exp;
    if (ent_wr[i])
    begin
      @(posedge clk);
      awvalid <= 1'b1;
      awaddr  <= ent_addr[i];
      awprot  <= ent_prot[i];
      wvalid  <= 1'b1;
      wdata   <= ent_data[i];
      wstrb   <= ent_strb[i];
      wait_accept(0);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      if (ent_resp[i] == RESP_OKAY)
        model_write(ent_addr[i], ent_data[i], ent_strb[i]);
      take_resp(0, ent_rdy[i], ent_resp[i], '0);
    end
    else
    begin
      // Error reads return the marker word
      exp = (ent_resp[i] == RESP_OKAY) ? model_read(ent_addr[i]) : `PU_ERR_DATA;
      @(posedge clk);
      arvalid <= 1'b1;
      araddr  <= ent_addr[i];
      arprot  <= ent_prot[i];
      wait_accept(1);
      arvalid <= 1'b0;
      take_resp(1, ent_rdy[i], ent_resp[i], exp);
    end
    check_outputs();
  endtask

  // Two writes fill the B slot and the third waits for bready
  task automatic write_burst();
    addr_t a [3];
    data_t d [3];
    resp_e e [3];
    int    got;
    int    n;
    bit    acc;
    a = '{7'h00, 7'h20, 7'h4C};
    e = '{RESP_OKAY, RESP_SLVERR, RESP_OKAY};
    for (int i = 0; i < 3; i++)
    begin
      d[i] = rand_bits(32);
      @(posedge clk);
      awvalid <= 1'b1;
      awaddr  <= a[i];
      awprot  <= 3'b001;
      wvalid  <= 1'b1;
      wdata   <= d[i];
      wstrb   <= 4'hF;
      if (i < 2)
      begin
        wait_accept(0);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (e[i] == RESP_OKAY)
          model_write(a[i], d[i], 4'hF);
      end
    end
    repeat (4)
    begin
      @(posedge clk);
      assert (!awready) else report_mismatch("awready_o", data_t'(awready), 32'd0);
      assert (!wready) else report_mismatch("wready_o", data_t'(wready), 32'd0);
      assert (bvalid) else report_mismatch("bvalid_o", data_t'(bvalid), 32'd1);
    end
    bready <= 1'b1;
    got = 0;
    n   = 0;
    acc = 0;
    while (got < 3 || !acc)
    begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        report_timeout("stalled write burst did not drain");
      if (bvalid && bready)
      begin
        assert (bresp == e[got]) else report_mismatch("bresp_o", data_t'(bresp), data_t'(e[got]));
        got++;
      end
      if (awvalid && awready)
      begin
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        acc = 1;
        model_write(a[2], d[2], 4'hF);
      end
    end
    bready <= 1'b0;
    check_outputs();
  endtask

  // Same for reads against the R slot
  task automatic read_burst();
    addr_t a [3];
    data_t x [3];
    resp_e e [3];
    int    got;
    int    n;
    bit    acc;
    a = '{7'h00, 7'h7C, 7'h4C};
    e = '{RESP_OKAY, RESP_SLVERR, RESP_OKAY};
    for (int i = 0; i < 3; i++)
    begin
      x[i] = (e[i] == RESP_OKAY) ? model_read(a[i]) : `PU_ERR_DATA;
      @(posedge clk);
      arvalid <= 1'b1;
      araddr  <= a[i];
      arprot  <= 3'b001;
      if (i < 2)
      begin
        wait_accept(1);
        arvalid <= 1'b0;
      end
    end
    repeat (4)
    begin
      @(posedge clk);
      assert (!arready) else report_mismatch("arready_o", data_t'(arready), 32'd0);
    end
    rready <= 1'b1;
    got = 0;
    n   = 0;
    acc = 0;
    while (got < 3 || !acc)
    begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT)
        report_timeout("stalled read burst did not drain");
      if (rvalid && rready)
      begin
        assert (rresp == e[got]) else report_mismatch("rresp_o", data_t'(rresp), data_t'(e[got]));
        assert (rdata == x[got]) else report_mismatch("rdata_o", rdata, x[got]);
        got++;
      end
      if (arvalid && arready)
      begin
        arvalid <= 1'b0;
        acc = 1;
      end
    end
    rready <= 1'b0;
  endtask

  initial
  begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    awprot  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    arprot  = '0;
    rready  = 1'b0;
    ctrl_m  = '0;
    for (int r = 0; r < `PU_NUM_MEM_REGIONS; r++)
      pol_m[r] = '0;
    // Response valids stay low while reset is held
    for (int i = 0; i < 16; i++)
    begin
      @(posedge clk);
      // Slot state is unknown before the first reset edge
      if (i > 0)
      begin
        assert (!bvalid) else report_mismatch("bvalid_o", data_t'(bvalid), 32'd0);
        assert (!rvalid) else report_mismatch("rvalid_o", data_t'(rvalid), 32'd0);
      end
    end
    rst_n <= 1'b1;
    build_table();
    for (int i = 0; i < ent_wr.size(); i++)
      apply_entry(i);
    write_burst();
    read_burst();
    check_outputs();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/pu_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module pu_cfg_top
  import pu_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   awvalid_i,
  input  addr_t                                  awaddr_i,
  input  prot_t                                  awprot_i,
  output logic                                   awready_o,
  input  logic                                   wvalid_i,
  input  data_t                                  wdata_i,
  input  strb_t                                  wstrb_i,
  output logic                                   wready_o,
  output logic                                   bvalid_o,
  output resp_e                                  bresp_o,
  input  logic                                   bready_i,
  input  logic                                   arvalid_i,
  input  addr_t                                  araddr_i,
  input  prot_t                                  arprot_i,
  output logic                                   arready_o,
  output logic                                   rvalid_o,
  output data_t                                  rdata_o,
  output resp_e                                  rresp_o,
  input  logic                                   rready_i,
  output data_t                                  ctrl_o,
  output policy_word_t [`PU_NUM_MEM_REGIONS-1:0] policy_o
);

  // Write side
  strb_t                           ctrl_upd;
  strb_t [`PU_NUM_MEM_REGIONS-1:0] policy_upd;
  logic                            b_push;
  logic                            b_ready;
  resp_e                           b_resp;
  logic [1:0]                      b_data;
  data_t                           ctrl_q;

  // Read side, response code above the data
  data_t                           r_data;
  resp_e                           r_resp;
  logic [`PU_DATA_WIDTH+1:0]       r_slot_data;

  pu_cfg_write_decode pu_cfg_write_decode_i (
    .awvalid_i    (awvalid_i),
    .awaddr_i     (awaddr_i),
    .awprot_i     (awprot_i),
    .awready_o    (awready_o),
    .wvalid_i     (wvalid_i),
    .wstrb_i      (wstrb_i),
    .wready_o     (wready_o),
    .ctrl_upd_o   (ctrl_upd),
    .policy_upd_o (policy_upd),
    .b_push_o     (b_push),
    .b_ready_i    (b_ready),
    .b_resp_o     (b_resp)
  );

  // Control word, byte enabled
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ctrl_q <= '0;
    end
    else
    begin
      for (int b = 0; b < `PU_STRB_WIDTH; b++)
      begin
        if (ctrl_upd[b])
        begin
          ctrl_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign ctrl_o = ctrl_q;

  // One policy register per memory region
  for (genvar r = 0; r < `PU_NUM_MEM_REGIONS; r++)
  begin : gen_policy_reg
    pu_policy_reg pu_policy_reg_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .upd_i    (policy_upd[r]),
      .wdata_i  (wdata_i),
      .policy_o (policy_o[r])
    );
  end

  // B slot cuts the path from AW/W to bvalid
  pu_resp_slot #(
    .WIDTH (2)
  ) pu_resp_slot_b_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (b_push),
    .ready_o (b_ready),
    .data_i  (b_resp),
    .valid_o (bvalid_o),
    .ready_i (bready_i),
    .data_o  (b_data)
  );

  assign bresp_o = resp_e'(b_data);

  // Read data sampled from register state before the accepting edge
  pu_cfg_read_mux pu_cfg_read_mux_i (
    .araddr_i (araddr_i),
    .arprot_i (arprot_i),
    .ctrl_i   (ctrl_q),
    .policy_i (policy_o),
    .rdata_o  (r_data),
    .rresp_o  (r_resp)
  );

  pu_resp_slot #(
    .WIDTH (`PU_DATA_WIDTH + 2)
  ) pu_resp_slot_r_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (arvalid_i),
    .ready_o (arready_o),
    .data_i  ({r_resp, r_data}),
    .valid_o (rvalid_o),
    .ready_i (rready_i),
    .data_o  (r_slot_data)
  );

  assign rdata_o = r_slot_data[`PU_DATA_WIDTH-1:0];
  assign rresp_o = resp_e'(r_slot_data[`PU_DATA_WIDTH +: 2]);

  // B response held steady until the master takes it
  a_b_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else $error("bvalid dropped or bresp changed before bready");

endmodule

`default_nettype wire

//--- src/pu_cfg_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module pu_cfg_read_mux
  import pu_pkg::*;
(
  input  addr_t                                  araddr_i,
  input  prot_t                                  arprot_i,
  input  data_t                                  ctrl_i,
  input  policy_word_t [`PU_NUM_MEM_REGIONS-1:0] policy_i,
  output data_t                                  rdata_o,
  output resp_e                                  rresp_o
);

  // Word addresses of the register map
  localparam addr_t CTRL_WORD = addr_t'(`PU_CTRL_OFFSET) >> `PU_WORD_LSB;
  localparam addr_t POLICY_LO = addr_t'(`PU_POLICY_BASE) >> `PU_WORD_LSB;
  localparam addr_t POLICY_HI = POLICY_LO + addr_t'(`PU_NUM_MEM_REGIONS);

  logic        prot_ok;
  addr_t       ar_word;
  region_idx_t ar_region;
  reg_sel_e    ar_sel;

  // Privilege check on prot bit 0
  assign prot_ok = !`PU_PRIV_PROT_ONLY || arprot_i[0];

  assign ar_word   = araddr_i >> `PU_WORD_LSB;
  assign ar_region = araddr_i[`PU_WORD_LSB +: `PU_REGION_IDX_WIDTH];

  // Address decode, same map as the write side
  always_comb
  begin
    if (ar_word == CTRL_WORD)
    begin
      ar_sel = SEL_CTRL;
    end
    else if ((ar_word >= POLICY_LO) && (ar_word < POLICY_HI))
    begin
      ar_sel = SEL_POLICY;
    end
    else
    begin
      ar_sel = SEL_NONE;
    end
  end

  // Data select
  // Default is the error marker with SLVERR
  always_comb
  begin
    rdata_o = `PU_ERR_DATA;
    rresp_o = RESP_SLVERR;
    if (prot_ok)
    begin
      case (ar_sel)
        SEL_CTRL:
        begin
          rdata_o = ctrl_i;
          rresp_o = RESP_OKAY;
        end
        SEL_POLICY:
        begin
          // Unstored domain bits read as zero
          rdata_o = data_t'(policy_i[ar_region]);
          rresp_o = RESP_OKAY;
        end
        default:
        begin
          rdata_o = `PU_ERR_DATA;
          rresp_o = RESP_SLVERR;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/pu_resp_slot.sv
`timescale 1ns/1ps
`default_nettype none

module pu_resp_slot #(
  parameter int unsigned WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Two payload entries used as a ring
  logic [WIDTH-1:0] mem_q [2];
  logic             wr_ptr_q;
  logic             rd_ptr_q;
  // Occupancy 0 to 2
  logic [1:0]       count_q;
  logic             push;
  logic             pop;

  // Handshakes depend on the count register alone
  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop)
      begin
        rd_ptr_q <= !rd_ptr_q;
      end
      // Push and pop together keep the count
      if (push && !pop)
      begin
        count_q <= count_q + 2'd1;
      end
      else if (pop && !push)
      begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  // Full slot with no pop must block the next push too
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q == 2'd2) && !pop |=> !push && (count_q == 2'd2))
    else $error("push into full slot, count %0d", count_q);

endmodule

`default_nettype wire

//--- src/pu_policy_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module pu_policy_reg
  import pu_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  strb_t        upd_i,
  input  data_t        wdata_i,
  output policy_word_t policy_o
);

  // Stored policy bits, only those of configured domains
  policy_word_t policy_q;

  // Bits above the configured domains have no flop
  // Each stored bit follows the strobe of the byte it sits in
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      policy_q <= '0;
    end
    else
    begin
      for (int i = 0; i < `PU_POLICY_WIDTH; i++)
      begin
        if (upd_i[i / 8])
        begin
          policy_q[i] <= wdata_i[i];
        end
      end
    end
  end

  assign policy_o = policy_q;

endmodule

`default_nettype wire

//--- src/pu_cfg_write_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "pu_defines.svh"

module pu_cfg_write_decode
  import pu_pkg::*;
(
  input  logic                                awvalid_i,
  input  addr_t                               awaddr_i,
  input  prot_t                               awprot_i,
  output logic                                awready_o,
  input  logic                                wvalid_i,
  input  strb_t                               wstrb_i,
  output logic                                wready_o,
  output strb_t                               ctrl_upd_o,
  output strb_t [`PU_NUM_MEM_REGIONS-1:0]     policy_upd_o,
  output logic                                b_push_o,
  input  logic                                b_ready_i,
  output resp_e                               b_resp_o
);

  // Word addresses of the register map
  localparam addr_t CTRL_WORD = addr_t'(`PU_CTRL_OFFSET) >> `PU_WORD_LSB;
  localparam addr_t POLICY_LO = addr_t'(`PU_POLICY_BASE) >> `PU_WORD_LSB;
  localparam addr_t POLICY_HI = POLICY_LO + addr_t'(`PU_NUM_MEM_REGIONS);

  logic        accept;
  logic        prot_ok;
  addr_t       aw_word;
  region_idx_t aw_region;
  reg_sel_e    aw_sel;
  logic [`PU_NUM_MEM_REGIONS-1:0] region_hit;

  // AW and W are taken together, and only with room in the B slot
  assign accept    = awvalid_i && wvalid_i && b_ready_i;
  assign awready_o = accept;
  assign wready_o  = accept;
  assign b_push_o  = accept;

  // Privilege check on prot bit 0
  assign prot_ok = !`PU_PRIV_PROT_ONLY || awprot_i[0];

  // Byte lanes are ignored for decode
  assign aw_word   = awaddr_i >> `PU_WORD_LSB;
  assign aw_region = awaddr_i[`PU_WORD_LSB +: `PU_REGION_IDX_WIDTH];

  always_comb
  begin
    if (aw_word == CTRL_WORD)
    begin
      aw_sel = SEL_CTRL;
    end
    else if ((aw_word >= POLICY_LO) && (aw_word < POLICY_HI))
    begin
      aw_sel = SEL_POLICY;
    end
    else
    begin
      aw_sel = SEL_NONE;
    end
  end

  // Strobes go to the one selected register
  always_comb
  begin
    ctrl_upd_o   = '0;
    policy_upd_o = '0;
    if (accept && prot_ok)
    begin
      case (aw_sel)
        SEL_CTRL:   ctrl_upd_o = wstrb_i;
        SEL_POLICY: policy_upd_o[aw_region] = wstrb_i;
        default:    ;
      endcase
    end
  end

  // Unmapped or unprivileged writes fail and store nothing
  assign b_resp_o = (prot_ok && (aw_sel != SEL_NONE)) ? RESP_OKAY : RESP_SLVERR;

  for (genvar r = 0; r < `PU_NUM_MEM_REGIONS; r++)
  begin : gen_region_hit
    assign region_hit[r] = |policy_upd_o[r];
  end

  // A store goes to one target only, and always comes with an OKAY push
  always_comb
  begin
    if (region_hit != '0 || ctrl_upd_o != '0)
    begin
      a_single_target : assert ($onehot({region_hit, |ctrl_upd_o})
                                && b_push_o && (b_resp_o == RESP_OKAY))
        else $error("write decode enabled %0h ctrl %0h", region_hit, ctrl_upd_o);
    end
  end

endmodule

`default_nettype wire

//--- src/pu_pkg.sv
`default_nettype none

`include "pu_defines.svh"

package pu_pkg;

  // Bus channel fields
  typedef logic [`PU_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`PU_DATA_WIDTH-1:0] data_t;
  typedef logic [`PU_STRB_WIDTH-1:0] strb_t;
  typedef logic [`PU_PROT_WIDTH-1:0] prot_t;

  // Index of one memory region
  typedef logic [`PU_REGION_IDX_WIDTH-1:0] region_idx_t;

  // One region's policy
  // Domain d has its read bit at 2d+1 and its write bit at 2d
  typedef logic [`PU_POLICY_WIDTH-1:0] policy_word_t;

  // Register targeted by a decoded address
  typedef enum logic [1:0] {
    SEL_NONE   = 2'd0,
    SEL_CTRL   = 2'd1,
    SEL_POLICY = 2'd2
  } reg_sel_e;

  // AXI response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

endpackage

`default_nettype wire

//--- include/pu_defines.svh
`ifndef PU_DEFINES_SVH
`define PU_DEFINES_SVH

// Memory regions with one policy word each
`define PU_NUM_MEM_REGIONS 4
// Region index width, log2 of the region count
`define PU_REGION_IDX_WIDTH 2

// Domains per policy word, at most 16
`define PU_NUM_DOMAINS 4
// Read and write bit per domain
`define PU_POLICY_WIDTH (2 * `PU_NUM_DOMAINS)

// Significant bus address bits
`define PU_ADDR_WIDTH 7
`define PU_DATA_WIDTH 32
`define PU_STRB_WIDTH (`PU_DATA_WIDTH / 8)
`define PU_PROT_WIDTH 3
// Byte offset bits within a word
`define PU_WORD_LSB 2

// Register map
`define PU_CTRL_OFFSET 7'h00
`define PU_POLICY_BASE 7'h40

// Marker returned with SLVERR reads
`define PU_ERR_DATA 32'hBA5E1E55

// Privileged accesses only, prot bit 0 must be set
`define PU_PRIV_PROT_ONLY 1'b1

`endif
